//--- hw/tx_iq_pkg.sv
// Widths, register map and types that every design unit of the tx I/Q path imports

package tx_iq_pkg;

  localparam int IQ_WIDTH   = 16; // one I or one Q component
  localparam int FUZZ_WIDTH = 6;  // signed fuzzer tap gain
  localparam int GAIN_WIDTH = 10; // signed baseband gain
  localparam int GAIN_SHIFT = 7;  // applied after the gain multiply

  // q in the upper half, i in the lower half
  typedef struct packed {
    logic signed [IQ_WIDTH-1:0] q;
    logic signed [IQ_WIDTH-1:0] i;
  } iq_pack_t;

  // software register map
  typedef enum logic [4:0] {
    REG_CTRL    = 5'd0, // bit 0 arbitrary mode, bit 1 trigger level
    REG_ARB_IQ  = 5'd1, // each write pushes one sample
    REG_BB_GAIN = 5'd2,
    REG_FUZZ    = 5'd3, // gain1 [5:0], rot1 [6], gain2 [13:8], rot2 [14]
    REG_HOLD_TH = 5'd4  // 10 bit threshold
  } reg_addr_e;

  // arbitrary i/q playback
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_PLAY = 1'b1
  } arb_state_e;

endpackage

//--- hw/tx_iq_cfg_if.sv
// Configuration bundle from the register block to the tx I/Q datapath, connected in the top level

`timescale 1ns/1ns

interface tx_iq_cfg_if;
  import tx_iq_pkg::*;

  logic signed [GAIN_WIDTH-1:0] bb_gain;
  logic signed [FUZZ_WIDTH-1:0] fuzz_gain1;
  logic                         fuzz_rot1;
  logic signed [FUZZ_WIDTH-1:0] fuzz_gain2;
  logic                         fuzz_rot2;
  logic [9:0]                   hold_threshold;
  logic                         arb_mode;
  logic                         arb_trigger;
  logic                         arb_push; // one cycle per software sample
  iq_pack_t                     arb_data; // valid with arb_push

  modport regs (
    output bb_gain, fuzz_gain1, fuzz_rot1, fuzz_gain2, fuzz_rot2,
    output hold_threshold, arb_mode, arb_trigger, arb_push, arb_data
  );

  modport datapath (
    input bb_gain, fuzz_gain1, fuzz_rot1, fuzz_gain2, fuzz_rot2,
    input hold_threshold, arb_mode, arb_trigger, arb_push, arb_data
  );

endinterface

//--- hw/tx_iq_regs.sv
// Register block that turns software writes into tx I/Q configuration and arbitrary sample pushes

`timescale 1ns/1ns

module tx_iq_regs (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 reg_wren,
  input  tx_iq_pkg::reg_addr_e reg_addr,
  input  logic [31:0]          reg_wdata,
  tx_iq_cfg_if.regs            cfg
);
  import tx_iq_pkg::*;

  logic arb_wr; // software write to the sample port

  assign arb_wr = reg_wren && (reg_addr == REG_ARB_IQ);

  // held configuration fields
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg.bb_gain        <= '0;
      cfg.fuzz_gain1     <= '0;
      cfg.fuzz_rot1      <= 1'b0;
      cfg.fuzz_gain2     <= '0;
      cfg.fuzz_rot2      <= 1'b0;
      cfg.hold_threshold <= '0;
      cfg.arb_mode       <= 1'b0;
      cfg.arb_trigger    <= 1'b0;
    end else if (reg_wren) begin
      case (reg_addr)
        REG_CTRL: begin
          cfg.arb_mode    <= reg_wdata[0];
          cfg.arb_trigger <= reg_wdata[1]; // level, edge is found downstream
        end
        REG_BB_GAIN: begin
          cfg.bb_gain <= reg_wdata[GAIN_WIDTH-1:0];
        end
        REG_FUZZ: begin
          cfg.fuzz_gain1 <= reg_wdata[FUZZ_WIDTH-1:0];
          cfg.fuzz_rot1  <= reg_wdata[6];
          cfg.fuzz_gain2 <= reg_wdata[8 +: FUZZ_WIDTH];
          cfg.fuzz_rot2  <= reg_wdata[14];
        end
        REG_HOLD_TH: begin
          cfg.hold_threshold <= reg_wdata[9:0];
        end
        default: ; // REG_ARB_IQ handled below, others ignored
      endcase
    end
  end

  // push strobe lands one cycle after the write
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg.arb_push <= 1'b0;
    end else begin
      cfg.arb_push <= arb_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (arb_wr) begin
      cfg.arb_data <= reg_wdata; // q in [31:16], i in [15:0]
    end
  end

  // software must space its sample writes, each push is a single pulse
  a_push_single: assert property (
    @(posedge clk) disable iff (!rstn)
    cfg.arb_push |=> !cfg.arb_push
  ) else $error("arb_push held for two cycles");

endmodule

//--- hw/iq_sync_fifo.sv
// Single-clock first-word-fall-through sample FIFO with occupancy count, used by the tx I/Q datapath

`timescale 1ns/1ns

module iq_sync_fifo #(
  parameter int DEPTH = 512
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       wr_en,
  input  tx_iq_pkg::iq_pack_t        din,
  input  logic                       rd_en,
  output tx_iq_pkg::iq_pack_t        dout,
  output logic                       empty,
  output logic                       full,
  output logic [$clog2(DEPTH+1)-1:0] count
);
  import tx_iq_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  iq_pack_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en && !full;  // overflow write is dropped
  assign do_rd = rd_en && !empty;

  assign empty = (count == '0);
  assign full  = (count == DEPTH[$clog2(DEPTH+1)-1:0]);
  assign dout  = mem[rd_ptr]; // head always visible

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rstn)
    wr_en |-> !full
  ) else $error("write to full FIFO, sample lost");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rstn)
    rd_en |-> !empty
  ) else $error("read from empty FIFO");

endmodule

//--- hw/csi_fuzzer.sv
// Two-tap complex FIR on the DAC sample stream that perturbs the channel state seen by a receiver

`timescale 1ns/1ns

module csi_fuzzer (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  tx_iq_pkg::iq_pack_t                     iq,
  input  logic                                    iq_valid,
  input  logic signed [tx_iq_pkg::FUZZ_WIDTH-1:0] gain1,
  input  logic signed [tx_iq_pkg::FUZZ_WIDTH-1:0] gain2,
  input  logic                                    rot1,
  input  logic                                    rot2,
  output tx_iq_pkg::iq_pack_t                     iq_out
);
  import tx_iq_pkg::*;

  // one spare bit so negating -32768 stays exact
  localparam int PROD_W = IQ_WIDTH + FUZZ_WIDTH + 1;

  iq_pack_t x1; // previous sample
  iq_pack_t x2; // two samples back

  logic signed [PROD_W-1:0] t1_i;
  logic signed [PROD_W-1:0] t1_q;
  logic signed [PROD_W-1:0] t2_i;
  logic signed [PROD_W-1:0] t2_q;
  logic signed [PROD_W-1:0] sum_i;
  logic signed [PROD_W-1:0] sum_q;

  // gain times component, optionally negated, scaled back by FUZZ_WIDTH-1
  function automatic logic signed [PROD_W-1:0] tap_mul(
    input logic signed [FUZZ_WIDTH-1:0] g,
    input logic signed [IQ_WIDTH-1:0]   x,
    input logic                         neg
  );
    logic signed [PROD_W-1:0] gw;
    logic signed [PROD_W-1:0] xw;
    logic signed [PROD_W-1:0] p;
    gw = g;
    xw = x;
    p  = gw * xw;
    if (neg) begin
      p = -p;
    end
    return p >>> (FUZZ_WIDTH - 1);
  endfunction

  // rotation by 90 degrees maps (i, q) to (-q, i)
  assign t1_i = rot1 ? tap_mul(gain1, x1.q, 1'b1) : tap_mul(gain1, x1.i, 1'b0);
  assign t1_q = rot1 ? tap_mul(gain1, x1.i, 1'b0) : tap_mul(gain1, x1.q, 1'b0);
  assign t2_i = rot2 ? tap_mul(gain2, x2.q, 1'b1) : tap_mul(gain2, x2.i, 1'b0);
  assign t2_q = rot2 ? tap_mul(gain2, x2.i, 1'b0) : tap_mul(gain2, x2.q, 1'b0);

  assign sum_i = PROD_W'($signed(iq.i)) + t1_i + t2_i;
  assign sum_q = PROD_W'($signed(iq.q)) + t1_q + t2_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      x1     <= '0;
      x2     <= '0;
      iq_out <= '0;
    end else if (iq_valid) begin
      x1       <= iq;
      x2       <= x1;
      iq_out.i <= sum_i[IQ_WIDTH-1:0]; // wraps, no saturation
      iq_out.q <= sum_q[IQ_WIDTH-1:0];
    end
  end

endmodule

//--- hw/tx_iq_intf.sv
// Tx I/Q datapath with gain, sample FIFO, arbitrary playback, fuzzer, hold and packet-on-DAC flag

`timescale 1ns/1ns

module tx_iq_intf #(
  parameter int FIFO_DEPTH = 512
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  tx_iq_cfg_if.datapath                         cfg,
  input  logic signed [tx_iq_pkg::IQ_WIDTH-1:0] rf_i,
  input  logic signed [tx_iq_pkg::IQ_WIDTH-1:0] rf_q,
  input  logic                                  rf_iq_valid,
  input  logic                                  dac_ready,
  input  logic                                  phy_tx_start,
  input  logic                                  tx_bb_is_ongoing,
  input  logic                                  iq_valid_for_check,
  output tx_iq_pkg::iq_pack_t                   iq_out,
  output logic                                  tx_hold,
  output logic                                  fifo_empty,
  output logic                                  pkt_iq_on_dac
);
  import tx_iq_pkg::*;

  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
  localparam int PROD_W = IQ_WIDTH + GAIN_WIDTH;

  logic signed [PROD_W-1:0] prod_i;
  logic signed [PROD_W-1:0] prod_q;
  logic                     bb_wren;

  iq_pack_t   fifo_din;
  iq_pack_t   fifo_dout;
  iq_pack_t   fuzz_in;
  logic       fifo_wren;
  logic       fifo_rden;
  logic       fifo_full;
  logic [CNT_W-1:0] fifo_count;

  arb_state_e arb_state;
  logic       trig_d;
  logic       trig_rise;
  logic       rd_allowed; // normal mode, or arbitrary playback running

  iq_pack_t   chk_iq;
  iq_pack_t   chk_iq_d;

  // gain stage, sample accepted only while not held
  always_ff @(posedge clk) begin
    prod_i <= rf_i * cfg.bb_gain;
    prod_q <= rf_q * cfg.bb_gain;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bb_wren <= 1'b0;
    end else begin
      bb_wren <= rf_iq_valid && !tx_hold;
    end
  end

  // write side mux
  assign fifo_din  = cfg.arb_mode ? cfg.arb_data
                                  : {prod_q[GAIN_SHIFT +: IQ_WIDTH], prod_i[GAIN_SHIFT +: IQ_WIDTH]};
  assign fifo_wren = cfg.arb_mode ? cfg.arb_push : bb_wren;

  // enough samples queued, throttle the tx core
  assign tx_hold = (fifo_count > CNT_W'(cfg.hold_threshold));

  // arbitrary playback control
  assign trig_rise = cfg.arb_trigger && !trig_d;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      trig_d    <= 1'b0;
      arb_state <= ARB_IDLE;
    end else begin
      trig_d <= cfg.arb_trigger;
      case (arb_state)
        ARB_IDLE: if (trig_rise && !fifo_empty) arb_state <= ARB_PLAY;
        ARB_PLAY: if (fifo_empty) arb_state <= ARB_IDLE;
        default:  arb_state <= ARB_IDLE;
      endcase
    end
  end

  // read side mux and zero fill
  assign rd_allowed = !cfg.arb_mode || (arb_state == ARB_PLAY);
  assign fifo_rden  = dac_ready && rd_allowed && !fifo_empty;
  assign fuzz_in    = (rd_allowed && !fifo_empty) ? fifo_dout : '0;

  iq_sync_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk   (clk),
    .rstn  (rstn),
    .wr_en (fifo_wren),
    .din   (fifo_din),
    .rd_en (fifo_rden),
    .dout  (fifo_dout),
    .empty (fifo_empty),
    .full  (fifo_full),
    .count (fifo_count)
  );

  // taps advance once per DAC pull
  csi_fuzzer u_fuzzer (
    .clk      (clk),
    .rstn     (rstn),
    .iq       (fuzz_in),
    .iq_valid (dac_ready),
    .gain1    (cfg.fuzz_gain1),
    .gain2    (cfg.fuzz_gain2),
    .rot1     (cfg.fuzz_rot1),
    .rot2     (cfg.fuzz_rot2),
    .iq_out   (iq_out)
  );

  // packet samples on the DAC, first non-zero after a zero marks the start
  always_ff @(posedge clk) begin
    if (!rstn || phy_tx_start) begin
      chk_iq        <= '0;
      chk_iq_d      <= '0;
      pkt_iq_on_dac <= 1'b0;
    end else begin
      chk_iq_d <= chk_iq;
      if (iq_valid_for_check) begin
        chk_iq <= iq_out;
      end
      if (!pkt_iq_on_dac) begin
        pkt_iq_on_dac <= (chk_iq_d == '0) && (chk_iq != '0);
      end else if (!tx_bb_is_ongoing) begin
        pkt_iq_on_dac <= 1'b0;
      end
    end
  end

  // baseband writes stop at the threshold so the FIFO should never fill in normal mode
  a_hold_before_full: assert property (
    @(posedge clk) disable iff (!rstn)
    (!cfg.arb_mode && fifo_full) |-> tx_hold
  ) else $error("FIFO full without tx_hold");

endmodule

//--- hw/tx_iq_top.sv
// Top level of the tx I/Q interface joining the register block and the datapath with plain ports

`timescale 1ns/1ns

module tx_iq_top #(
  parameter int FIFO_DEPTH = 512
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  reg_wren,
  input  logic [4:0]                            reg_addr,
  input  logic [31:0]                           reg_wdata,
  input  logic signed [tx_iq_pkg::IQ_WIDTH-1:0] rf_i,
  input  logic signed [tx_iq_pkg::IQ_WIDTH-1:0] rf_q,
  input  logic                                  rf_iq_valid,
  input  logic                                  dac_ready, // DAC read strobe
  input  logic                                  phy_tx_start,
  input  logic                                  tx_bb_is_ongoing,
  input  logic                                  iq_valid_for_check,
  output tx_iq_pkg::iq_pack_t                   iq_out,
  output logic                                  tx_hold,
  output logic                                  fifo_empty,
  output logic                                  pkt_iq_on_dac
);
  import tx_iq_pkg::*;

  tx_iq_cfg_if cfg_if ();

  tx_iq_regs u_regs (
    .clk       (clk),
    .rstn      (rstn),
    .reg_wren  (reg_wren),
    .reg_addr  (reg_addr_e'(reg_addr)),
    .reg_wdata (reg_wdata),
    .cfg       (cfg_if)
  );

  tx_iq_intf #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_intf (
    .clk                (clk),
    .rstn               (rstn),
    .cfg                (cfg_if),
    .rf_i               (rf_i),
    .rf_q               (rf_q),
    .rf_iq_valid        (rf_iq_valid),
    .dac_ready          (dac_ready),
    .phy_tx_start       (phy_tx_start),
    .tx_bb_is_ongoing   (tx_bb_is_ongoing),
    .iq_valid_for_check (iq_valid_for_check),
    .iq_out             (iq_out),
    .tx_hold            (tx_hold),
    .fifo_empty         (fifo_empty),
    .pkt_iq_on_dac      (pkt_iq_on_dac)
  );

endmodule

//--- verification/tb_tx_iq_top.sv
// Directed testbench for the tx I/Q top level, compiled and run from the Verilator script

`timescale 1ns/1ns

module tb_tx_iq_top;
  import tx_iq_pkg::*;

  logic                       clk = 1'b0;
  logic                       rstn;
  logic                       reg_wren;
  logic [4:0]                 reg_addr;
  logic [31:0]                reg_wdata;
  logic signed [IQ_WIDTH-1:0] rf_i;
  logic signed [IQ_WIDTH-1:0] rf_q;
  logic                       rf_iq_valid;
  logic                       dac_ready;
  logic                       phy_tx_start;
  logic                       tx_bb_is_ongoing;
  logic                       iq_valid_for_check;
  iq_pack_t                   iq_out;
  logic                       tx_hold;
  logic                       fifo_empty;
  logic                       pkt_iq_on_dac;

  int       errors = 0;
  int       checks = 0;
  integer   seed = 37;
  iq_pack_t exp_q [$]; // expected FIFO contents, head first
  iq_pack_t hist1 = '0; // expected fuzzer taps
  iq_pack_t hist2 = '0;
  int       bb_gain_m = 0;
  int       hold_th_m = 0;
  int       g1_m = 0;
  int       g2_m = 0;
  logic     r1_m = 1'b0;
  logic     r2_m = 1'b0;
  logic     arb_mode_m = 1'b0;
  logic     trig_m = 1'b0;
  logic     arb_play_m = 1'b0;

  tx_iq_top #(.FIFO_DEPTH(512)) uut (
    .clk(clk), .rstn(rstn), .reg_wren(reg_wren), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
    .rf_i(rf_i), .rf_q(rf_q), .rf_iq_valid(rf_iq_valid), .dac_ready(dac_ready),
    .phy_tx_start(phy_tx_start), .tx_bb_is_ongoing(tx_bb_is_ongoing),
    .iq_valid_for_check(iq_valid_for_check), .iq_out(iq_out), .tx_hold(tx_hold),
    .fifo_empty(fifo_empty), .pkt_iq_on_dac(pkt_iq_on_dac)
  );

  always #20 clk = ~clk;

  task automatic check_iq(input string name, input iq_pack_t got, input iq_pack_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  // component times gain, arithmetic shift, keep the low IQ_WIDTH bits
  function automatic logic [IQ_WIDTH-1:0] apply_gain(input logic signed [IQ_WIDTH-1:0] x);
    int p;
    p = int'(x) * bb_gain_m;
    p = p >>> GAIN_SHIFT;
    return p[IQ_WIDTH-1:0];
  endfunction

  // current sample plus both taps, a set flag turns (i, q) into (-q, i)
  function automatic iq_pack_t fuzz_expect(input iq_pack_t cur);
    int       ai;
    int       aq;
    int       bi;
    int       bq;
    int       si;
    int       sq;
    iq_pack_t r;
    ai = r1_m ? -int'(hist1.q) : int'(hist1.i);
    aq = r1_m ? int'(hist1.i) : int'(hist1.q);
    bi = r2_m ? -int'(hist2.q) : int'(hist2.i);
    bq = r2_m ? int'(hist2.i) : int'(hist2.q);
    si = int'(cur.i) + ((g1_m * ai) >>> (FUZZ_WIDTH - 1)) + ((g2_m * bi) >>> (FUZZ_WIDTH - 1));
    sq = int'(cur.q) + ((g1_m * aq) >>> (FUZZ_WIDTH - 1)) + ((g2_m * bq) >>> (FUZZ_WIDTH - 1));
    r.i = si[IQ_WIDTH-1:0];
    r.q = sq[IQ_WIDTH-1:0];
    return r;
  endfunction

  // idle cycle at the end keeps sample pushes apart
  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    iq_pack_t s;
    reg_wren  = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wren = 1'b0;
    @(negedge clk);
    s = data;
    case (addr)
      REG_CTRL: begin
        if (data[1] && !trig_m && exp_q.size() > 0) arb_play_m = 1'b1;
        arb_mode_m = data[0];
        trig_m     = data[1];
      end
      REG_ARB_IQ:  if (arb_mode_m) exp_q.push_back(s);
      REG_BB_GAIN: bb_gain_m = int'($signed(data[GAIN_WIDTH-1:0]));
      REG_FUZZ: begin
        g1_m = int'($signed(data[5:0]));
        r1_m = data[6];
        g2_m = int'($signed(data[13:8]));
        r2_m = data[14];
      end
      REG_HOLD_TH: hold_th_m = int'(data[9:0]);
      default: ;
    endcase
  endtask

  task automatic send_rf(input logic signed [IQ_WIDTH-1:0] i, input logic signed [IQ_WIDTH-1:0] q);
    iq_pack_t s;
    s.i = apply_gain(i);
    s.q = apply_gain(q);
    if (!arb_mode_m && exp_q.size() <= hold_th_m) exp_q.push_back(s); // hold drops the rest
    rf_i        = i;
    rf_q        = q;
    rf_iq_valid = 1'b1;
    @(negedge clk);
    rf_iq_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic pull_dac(output iq_pack_t got);
    dac_ready = 1'b1;
    @(negedge clk);
    dac_ready = 1'b0;
    got = iq_out; // updated on the edge that consumed the sample
  endtask

  task automatic pull_and_compare();
    iq_pack_t cur;
    iq_pack_t exp;
    iq_pack_t got;
    cur = '0; // empty or idle FIFO feeds zero
    if ((!arb_mode_m || arb_play_m) && exp_q.size() > 0) cur = exp_q.pop_front();
    if (exp_q.size() == 0) arb_play_m = 1'b0;
    exp   = fuzz_expect(cur);
    hist2 = hist1;
    hist1 = cur;
    pull_dac(got);
    check_iq("iq_out", got, exp);
  endtask

  task automatic capture_iq();
    iq_valid_for_check = 1'b1;
    @(negedge clk);
    iq_valid_for_check = 1'b0;
  endtask

  task automatic wait_pkt(input logic level);
    int n;
    n = 0;
    while (pkt_iq_on_dac !== level && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (pkt_iq_on_dac !== level) begin
      errors++;
      $display("timeout while waiting for pkt_iq_on_dac to become %0b", level);
    end
  endtask

  task automatic after_reset();
    check_bit("tx_hold", tx_hold, 1'b0);
    check_bit("pkt_iq_on_dac", pkt_iq_on_dac, 1'b0);
    check_bit("fifo_empty", fifo_empty, 1'b1);
    pull_and_compare();
  endtask

  task automatic gain_path();
    integer r;
    write_reg(REG_HOLD_TH, 32'd64);
    write_reg(REG_BB_GAIN, 32'h3b5); // -75
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      send_rf(r[15:0], r[31:16]);
    end
    while (exp_q.size() > 0) pull_and_compare();
    check_bit("fifo_empty", fifo_empty, 1'b1);
  endtask

  task automatic hold_limit();
    integer r;
    write_reg(REG_HOLD_TH, 32'd4);
    for (int k = 0; k < 10; k++) begin
      r = $random(seed);
      send_rf(r[15:0], r[31:16]);
    end
    check_bit("tx_hold", tx_hold, exp_q.size() > hold_th_m);
    while (exp_q.size() > 0) pull_and_compare();
    check_bit("fifo_empty", fifo_empty, 1'b1);
    check_bit("tx_hold", tx_hold, 1'b0);
  endtask

  task automatic fuzzer_taps();
    write_reg(REG_BB_GAIN, 32'h080); // unity after the shift
    write_reg(REG_FUZZ, 32'h0000_0974); // gain1 -12 rotated, gain2 9
    send_rf(16'sd1000, -16'sd2000);
    send_rf(-16'sd3000, 16'sd500);
    send_rf(16'sd12000, 16'sd7000);
    send_rf(-16'sd32768, 16'sd32767);
    repeat (6) pull_and_compare(); // last two show the tap tails
  endtask

  task automatic arb_playback();
    integer r;
    write_reg(REG_FUZZ, 32'd0);
    write_reg(REG_CTRL, 32'd1);
    for (int k = 0; k < 6; k++) begin
      r = $random(seed);
      write_reg(REG_ARB_IQ, r);
    end
    repeat (2) pull_and_compare(); // idle, zero out
    check_bit("fifo_empty", fifo_empty, 1'b0);
    write_reg(REG_CTRL, 32'd3);
    repeat (8) pull_and_compare();
    check_bit("fifo_empty", fifo_empty, 1'b1);
    write_reg(REG_CTRL, 32'd0);
  endtask

  task automatic pkt_detector();
    tx_bb_is_ongoing = 1'b1;
    phy_tx_start     = 1'b1;
    @(negedge clk);
    phy_tx_start = 1'b0;
    capture_iq(); // iq_out is zero here
    @(negedge clk);
    check_bit("pkt_iq_on_dac", pkt_iq_on_dac, 1'b0);
    send_rf(16'sh1234, 16'sh0567);
    pull_and_compare();
    capture_iq();
    wait_pkt(1'b1);
    tx_bb_is_ongoing = 1'b0;
    wait_pkt(1'b0);
    tx_bb_is_ongoing = 1'b1;
    phy_tx_start     = 1'b1;
    @(negedge clk);
    phy_tx_start = 1'b0;
    capture_iq();
    wait_pkt(1'b1);
    phy_tx_start = 1'b1;
    @(negedge clk);
    phy_tx_start = 1'b0;
    check_bit("pkt_iq_on_dac", pkt_iq_on_dac, 1'b0);
  endtask

  initial begin
    rstn               = 1'b0;
    reg_wren           = 1'b0;
    reg_addr           = '0;
    reg_wdata          = '0;
    rf_i               = '0;
    rf_q               = '0;
    rf_iq_valid        = 1'b0;
    dac_ready          = 1'b0;
    phy_tx_start       = 1'b0;
    tx_bb_is_ongoing   = 1'b0;
    iq_valid_for_check = 1'b0;
    repeat (5) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    after_reset();
    gain_path();
    hold_limit();
    fuzzer_taps();
    arb_playback();
    pkt_detector();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/tx_iq_pkg.sv
hw/tx_iq_cfg_if.sv
hw/tx_iq_regs.sv
hw/iq_sync_fifo.sv
hw/csi_fuzzer.sv
hw/tx_iq_intf.sv
hw/tx_iq_top.sv
verification/tb_tx_iq_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_tx_iq_top -o sim_tb_tx_iq_top

out="$(./obj_dir/sim_tb_tx_iq_top)"
echo "$out"

if echo "$out" | grep -q "^All tests passed$"; then
  exit 0
else
  exit 1
fi
